//--- Bender.yml
package:
  name: loop_buffer

sources:
  - include_dirs:
      - design
    files:
      - design/loop_pkg.sv
      - design/back_edge_detect.sv
      - design/loop_addr_table.sv
      - design/loop_unroll_ctrl.sv
      - design/loop_buffer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/loop_buffer_tb.sv

//--- bench/loop_buffer_tb.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module loop_buffer_tb
	import loop_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	// bundles per phase
	// reset, idle probes, loop a, loop b, loops c to e, table probes, long body
	localparam int STIM_CYCLES = 8 + 4 + 22 + 42 + 9 + 9 + 20;

	logic clk;
	logic rst;
	fetch_bundle_t fetch;
	logic mis_pred;
	loop_state_e lbd_state;
	logic loop_strt;
	logic fnsh_unrll;
	logic stll_ftch;
	logic [`LANES-1:0] inst_valid;

	string test_name;
	logic stall_seen;

	// reference model registers
	loop_state_e m_state;
	logic [`ADDR_W-1:0] m_trn_start;
	logic [`ADDR_W-1:0] m_trn_end;
	logic [`ADDR_W-1:0] m_dsp_end;
	int m_cnt;
	int m_remain;
	int m_stall;
	int m_ptr;
	logic m_valid [`LAT_DEPTH];
	logic [`ADDR_W-1:0] m_start [`LAT_DEPTH];
	logic [`ADDR_W-1:0] m_end [`LAT_DEPTH];
	int m_unroll [`LAT_DEPTH];

	// model view of the current bundle
	logic e_hit;
	int e_idx;
	logic e_back;
	logic [`ADDR_W-1:0] e_br;
	logic [`ADDR_W-1:0] e_tgt;
	logic [`ADDR_W-1:0] e_end;
	logic e_match;
	int e_lanes;
	logic e_strt;
	logic e_fnsh;
	logic e_stll;
	logic [`LANES-1:0] e_valid;

	loop_buffer_top u_loop_buffer_top (
		.clk        (clk),
		.rst        (rst),
		.fetch      (fetch),
		.mis_pred   (mis_pred),
		.lbd_state  (lbd_state),
		.loop_strt  (loop_strt),
		.fnsh_unrll (fnsh_unrll),
		.stll_ftch  (stll_ftch),
		.inst_valid (inst_valid)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic report_mismatch(input string what, input int expv, input int actv);
		fail_now($sformatf("Error: test %s, %s expected %0h, actual %0h",
			test_name, what, expv, actv));
	endtask

	// sequential lanes from base with a branch word at br_pc
	task automatic drive_bundle(input logic [`ADDR_W-1:0] base,
		input logic [`ADDR_W-1:0] br_pc, input int len, input logic mp);
		fetch_bundle_t b;
		logic [`INST_W-1:0] w;
		for (int i = 0; i < `LANES; i++) begin
			b.pc[i] = base + (`ADDR_W)'(i);
			w = (`INST_W)'($urandom);
			// filler never decodes as a branch
			if (w[`INST_W-1 -: 4] == `BR_OPCODE) begin
				w[`INST_W-1 -: 4] = 4'h0;
			end
			// offset points back to the first body slot
			b.inst[i] = (b.pc[i] == br_pc) ? {`BR_OPCODE, 12'(1 - len)} : w;
		end
		fetch <= b;
		mis_pred <= mp;
		@(posedge clk);
		if (stll_ftch) begin
			stall_seen = 1'b1;
		end
	endtask

	// branch spotted in lane 2 then one pass over the body
	task automatic train_loop(input logic [`ADDR_W-1:0] start, input int len);
		logic [`ADDR_W-1:0] end_pc;
		logic [`ADDR_W-1:0] base;
		end_pc = start + (`ADDR_W)'(len - 1);
		drive_bundle(end_pc - 16'd2, end_pc, len, 1'b0);
		base = start;
		while (base + 16'd3 < end_pc) begin
			drive_bundle(base, end_pc, len, 1'b0);
			base += 16'd4;
		end
		drive_bundle(base, end_pc, len, 1'b0);
	endtask

	// lane 0 on a start address without branch words
	task automatic probe_start(input logic [`ADDR_W-1:0] start, input logic exp_strt);
		drive_bundle(start, 16'h0, 0, 1'b0);
		assert (loop_strt === exp_strt)
		else report_mismatch("loop_strt", exp_strt, loop_strt);
	endtask

	// iterations until fnsh_unrll or the limit
	// end lane rotates through all four slots
	task automatic unroll_loop(input logic [`ADDR_W-1:0] start, input int len,
		input int limit, output int iters, output logic done);
		logic [`ADDR_W-1:0] end_pc;
		logic [`ADDR_W-1:0] base;
		end_pc = start + (`ADDR_W)'(len - 1);
		iters = 0;
		done = 1'b0;
		while (!done && iters < limit) begin
			base = start;
			while (base + 16'd3 < end_pc) begin
				drive_bundle(base, end_pc, len, 1'b0);
				base += 16'd4;
			end
			drive_bundle(end_pc - (`ADDR_W)'(iters % 4), end_pc, len, 1'b0);
			iters++;
			done = fnsh_unrll;
		end
	endtask

	always_comb begin
		// first valid start match on lane 0
		e_hit = 1'b0;
		e_idx = 0;
		for (int i = 0; i < `LAT_DEPTH; i++) begin
			if (!e_hit && m_valid[i] && m_start[i] == fetch.pc[0]) begin
				e_hit = 1'b1;
				e_idx = i;
			end
		end
		// oldest branch with a negative offset
		e_back = 1'b0;
		e_br = '0;
		e_tgt = '0;
		for (int i = 0; i < `LANES; i++) begin
			if (!e_back && fetch.inst[i][15:12] == `BR_OPCODE && fetch.inst[i][11]) begin
				e_back = 1'b1;
				e_br = fetch.pc[i];
				e_tgt = fetch.pc[i] + {4'hf, fetch.inst[i][11:0]};
			end
		end
		e_end = (m_state == TRAIN) ? m_trn_end : m_dsp_end;
		e_match = 1'b0;
		e_lanes = `LANES;
		for (int i = 0; i < `LANES; i++) begin
			if (!e_match && fetch.pc[i] == e_end) begin
				e_match = 1'b1;
				e_lanes = i + 1;
			end
		end
		e_strt = e_hit && (m_state != DISPATCH);
		e_fnsh = (m_state == DISPATCH) && e_match && (m_remain == 1);
		e_stll = (m_stall >= `BUF_SLOTS);
		// lane 0 in the top bit
		for (int i = 0; i < `LANES; i++) begin
			e_valid[`LANES-1-i] = (m_state != DISPATCH) || (i < e_lanes);
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			m_state <= IDLE;
			m_cnt <= 0;
			m_remain <= 0;
			m_stall <= 0;
			m_ptr <= 0;
			for (int i = 0; i < `LAT_DEPTH; i++) begin
				m_valid[i] <= 1'b0;
			end
		end else if (m_state == DISPATCH) begin
			if (mis_pred || e_fnsh) begin
				m_state <= IDLE;
				m_remain <= 0;
				m_stall <= 0;
			end else begin
				if (e_match) begin
					m_remain <= m_remain - 1;
				end
				m_stall <= m_stall + e_lanes;
			end
		end else if (e_strt) begin
			m_state <= DISPATCH;
			m_remain <= m_unroll[e_idx];
			m_dsp_end <= m_end[e_idx];
			m_stall <= 0;
		end else if (m_state == IDLE) begin
			if (e_back) begin
				m_state <= TRAIN;
				m_trn_end <= e_br;
				m_trn_start <= e_tgt;
				m_cnt <= 0;
			end
		end else if (e_match) begin
			// body fits, record it in the round robin slot
			if (m_cnt + e_lanes <= `BUF_SLOTS) begin
				m_valid[m_ptr] <= 1'b1;
				m_start[m_ptr] <= m_trn_start;
				m_end[m_ptr] <= m_trn_end;
				m_unroll[m_ptr] <= `BUF_SLOTS / (m_cnt + e_lanes);
				m_ptr <= (m_ptr + 1) % `LAT_DEPTH;
			end
			m_state <= IDLE;
		end else begin
			m_cnt <= m_cnt + e_lanes;
		end
	end

	// dut ports against the model
	assert property (@(posedge clk) disable iff (rst) lbd_state == m_state)
	else report_mismatch("lbd_state", $sampled(m_state), $sampled(lbd_state));
	assert property (@(posedge clk) disable iff (rst) loop_strt == e_strt)
	else report_mismatch("loop_strt", $sampled(e_strt), $sampled(loop_strt));
	assert property (@(posedge clk) disable iff (rst) fnsh_unrll == e_fnsh)
	else report_mismatch("fnsh_unrll", $sampled(e_fnsh), $sampled(fnsh_unrll));
	assert property (@(posedge clk) disable iff (rst) stll_ftch == e_stll)
	else report_mismatch("stll_ftch", $sampled(e_stll), $sampled(stll_ftch));
	assert property (@(posedge clk) disable iff (rst) inst_valid == e_valid)
	else report_mismatch("inst_valid", $sampled(e_valid), $sampled(inst_valid));

	initial begin
		#((STIM_CYCLES + 200) * CLK_PERIOD);
		fail_now("watchdog expired, the run hung");
	end

	initial begin
		int iters;
		logic done;
		void'($urandom(32'hbf64_a4c8));
		rst = 1'b1;
		mis_pred = 1'b0;
		fetch = '0;
		stall_seen = 1'b0;
		test_name = "reset";
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		// nothing recorded yet
		for (int k = 0; k < 3; k++) begin
			drive_bundle(16'h7000 + (`ADDR_W)'(4 * k), 16'h0, 0, 1'b0);
		end
		probe_start(16'h7010, 1'b0);

		// 16 instructions give a budget of 4
		test_name = "training";
		train_loop(16'h0100, 16);
		probe_start(16'h0100, 1'b1);
		test_name = "dispatch";
		unroll_loop(16'h0100, 16, 8, iters, done);
		assert (done) else fail_now("fnsh_unrll never rose for the 16-instruction loop");
		assert (iters == 4) else report_mismatch("unroll count", 4, iters);

		// 2 instructions give a budget of 32
		// cut short by a mispredict and restarted
		test_name = "mispredict";
		train_loop(16'h0200, 2);
		probe_start(16'h0200, 1'b1);
		unroll_loop(16'h0200, 2, 5, iters, done);
		assert (!done) else fail_now("the 2-instruction loop finished before the mispredict");
		drive_bundle(16'h7100, 16'h0, 0, 1'b1);
		test_name = "stall";
		probe_start(16'h0200, 1'b1);
		unroll_loop(16'h0200, 2, 40, iters, done);
		assert (done) else fail_now("fnsh_unrll never rose for the 2-instruction loop");
		assert (iters == 32) else report_mismatch("unroll count", 32, iters);

		// fifth loop evicts the first
		test_name = "replacement";
		train_loop(16'h0300, 8);
		train_loop(16'h0400, 12);
		train_loop(16'h0500, 4);
		probe_start(16'h0100, 1'b0);
		for (int k = 2; k <= 5; k++) begin
			probe_start((`ADDR_W)'(k * 16'h0100), 1'b1);
			drive_bundle(16'h7200, 16'h0, 0, 1'b1);
		end
		// 68 instructions overflow the buffer
		train_loop(16'h0600, 68);
		probe_start(16'h0600, 1'b0);
		drive_bundle(16'h7300, 16'h0, 0, 1'b0);

		if (stall_seen) begin
			$display("Testbench passed");
			$finish;
		end else begin
			fail_now("stll_ftch never rose while the 2-instruction loop unrolled");
		end
	end

endmodule

//--- design/back_edge_detect.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module back_edge_detect
	import loop_pkg::*;
(
	input  fetch_bundle_t fetch,
	output back_edge_t    back_edge
);

	// per lane branch decode
	logic [`INST_W-5:0] off [`LANES];
	logic [`LANES-1:0] is_back;
	logic [`ADDR_W-1:0] tgt [`LANES];

	always_comb begin
		for (int i = 0; i < `LANES; i++) begin
			// low bits of a branch word
			off[i] = fetch.inst[i][`INST_W-5:0];
			// branch opcode with the offset sign set
			is_back[i] = (fetch.inst[i][`INST_W-1 -: 4] == `BR_OPCODE) &&
				off[i][`INST_W-5];
			// sign extended add onto the branch address
			tgt[i] = fetch.pc[i] + (`ADDR_W)'($signed(off[i]));
		end
	end

	// priority pick
	// walk from the youngest lane down so the oldest hit wins
	always_comb begin
		back_edge = '0;
		for (int i = `LANES - 1; i >= 0; i--) begin
			if (is_back[i]) begin
				back_edge.hit = 1'b1;
				back_edge.lane = ($clog2(`LANES))'(i);
				back_edge.br_addr = fetch.pc[i];
				back_edge.tgt_addr = tgt[i];
			end
		end
	end

	// a backward offset must not wrap past address zero
	// otherwise the recorded loop start lands above its end
	always_comb begin
		if (back_edge.hit) begin
			assert final (back_edge.tgt_addr <= back_edge.br_addr)
			else $error("back_edge_detect: target %h above branch %h",
				back_edge.tgt_addr, back_edge.br_addr);
		end
	end

endmodule

//--- design/loop_addr_table.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module loop_addr_table
	import loop_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               wr_en,
	input  lat_entry_t         wr_entry,
	input  logic [`ADDR_W-1:0] lookup_pc,
	output lat_lookup_t        lookup
);

	// table storage
	lat_entry_t lat [`LAT_DEPTH];
	// round robin victim pointer
	// wraps to the oldest entry once all slots are used
	logic [$clog2(`LAT_DEPTH)-1:0] wr_ptr;
	// start address match per entry
	logic [`LAT_DEPTH-1:0] hit_vec;
	// table holds unique start addresses
	logic no_dup;

	// reset clears the valid bits and the pointer
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `LAT_DEPTH; i++) begin
				lat[i].valid <= 1'b0;
			end
			wr_ptr <= '0;
		end else if (wr_en) begin
			lat[wr_ptr] <= wr_entry;
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// compare lane 0 pc against every valid start
	always_comb begin
		for (int i = 0; i < `LAT_DEPTH; i++) begin
			hit_vec[i] = lat[i].valid && (lat[i].start_addr == lookup_pc);
		end
	end

	// first matching entry
	// scan backwards so the lowest index is kept
	always_comb begin
		lookup = '0;
		for (int i = `LAT_DEPTH - 1; i >= 0; i--) begin
			if (hit_vec[i]) begin
				lookup.hit = 1'b1;
				lookup.end_addr = lat[i].end_addr;
				lookup.max_unroll = lat[i].max_unroll;
			end
		end
	end

	// pairwise start address check over valid entries
	always_comb begin
		no_dup = 1'b1;
		for (int i = 0; i < `LAT_DEPTH; i++) begin
			for (int j = i + 1; j < `LAT_DEPTH; j++) begin
				if (lat[i].valid && lat[j].valid &&
					(lat[i].start_addr == lat[j].start_addr)) begin
					no_dup = 1'b0;
				end
			end
		end
	end

	// a freshly trained loop never shadows a recorded one
	// the controller only trains when the start missed in the table
	assert property (@(posedge clk) disable iff (rst)
		wr_en |=> no_dup)
	else $error("loop_addr_table: duplicate start address after write");

endmodule

//--- design/loop_buffer_top.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module loop_buffer_top
	import loop_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  fetch_bundle_t       fetch,
	input  logic                mis_pred,
	output loop_state_e         lbd_state,
	output logic                loop_strt,
	output logic                fnsh_unrll,
	output logic                stll_ftch,
	output logic [`LANES-1:0]   inst_valid
);

	// detector result
	back_edge_t back_edge;
	// table lookup on lane 0
	lat_lookup_t lookup;
	// training write into the table
	logic wr_en;
	lat_entry_t wr_entry;

	// oldest backward branch of the bundle
	back_edge_detect u_back_edge_detect (
		.fetch     (fetch),
		.back_edge (back_edge)
	);

	// recorded loops keyed by start address
	loop_addr_table u_loop_addr_table (
		.clk       (clk),
		.rst       (rst),
		.wr_en     (wr_en),
		.wr_entry  (wr_entry),
		.lookup_pc (fetch.pc[0]),
		.lookup    (lookup)
	);

	// train and dispatch fsm
	loop_unroll_ctrl u_loop_unroll_ctrl (
		.clk        (clk),
		.rst        (rst),
		.fetch      (fetch),
		.back_edge  (back_edge),
		.lookup     (lookup),
		.mis_pred   (mis_pred),
		.wr_en      (wr_en),
		.wr_entry   (wr_entry),
		.lbd_state  (lbd_state),
		.loop_strt  (loop_strt),
		.fnsh_unrll (fnsh_unrll),
		.stll_ftch  (stll_ftch),
		.inst_valid (inst_valid)
	);

endmodule

//--- design/loop_consts.svh
`ifndef LOOP_CONSTS_SVH
`define LOOP_CONSTS_SVH

// fetch bundle geometry
// lane 0 is the oldest slot
`define LANES 4
`define ADDR_W 16
`define INST_W 16

// loop address table entries
`define LAT_DEPTH 4

// buffer capacity in instructions
// also caps the recordable body length
`define BUF_SLOTS 64

// instruction, unroll and stall counters
// one bit over BUF_SLOTS so 64 itself fits
`define CNT_W 7

// top nibble of a branch word
// low 12 bits hold the signed offset
`define BR_OPCODE 4'hc

`endif

//--- design/loop_pkg.sv
`include "loop_consts.svh"

package loop_pkg;

	// loop detector fsm
	// idle, train and dispatch in encoding order
	typedef enum logic [1:0] {
		IDLE     = 2'b00,
		TRAIN    = 2'b01,
		DISPATCH = 2'b10
	} loop_state_e;

	// one fetch bundle
	// index 0 sits in the top bits of each 64-bit word
	typedef struct packed {
		logic [0:`LANES-1][`ADDR_W-1:0] pc;
		logic [0:`LANES-1][`INST_W-1:0] inst;
	} fetch_bundle_t;

	// oldest backward branch in the bundle
	typedef struct packed {
		logic                       hit;
		logic [$clog2(`LANES)-1:0]  lane;
		logic [`ADDR_W-1:0]         br_addr;
		logic [`ADDR_W-1:0]         tgt_addr;
	} back_edge_t;

	// loop address table entry
	// start is the branch target, end is the branch itself
	typedef struct packed {
		logic                valid;
		logic [`ADDR_W-1:0]  start_addr;
		logic [`ADDR_W-1:0]  end_addr;
		logic [`CNT_W-1:0]   body_len;
		logic [`CNT_W-1:0]   max_unroll;
	} lat_entry_t;

	// result of a start address lookup
	typedef struct packed {
		logic                hit;
		logic [`ADDR_W-1:0]  end_addr;
		logic [`CNT_W-1:0]   max_unroll;
	} lat_lookup_t;

endpackage

//--- design/loop_unroll_ctrl.sv
`timescale 1ns/1ps
`include "loop_consts.svh"

module loop_unroll_ctrl
	import loop_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  fetch_bundle_t       fetch,
	input  back_edge_t          back_edge,
	input  lat_lookup_t         lookup,
	input  logic                mis_pred,
	output logic                wr_en,
	output lat_entry_t          wr_entry,
	output loop_state_e         lbd_state,
	output logic                loop_strt,
	output logic                fnsh_unrll,
	output logic                stll_ftch,
	output logic [`LANES-1:0]   inst_valid
);

	// fsm state
	loop_state_e state;

	// training bounds and running body length
	logic [`ADDR_W-1:0] trn_start;
	logic [`ADDR_W-1:0] trn_end;
	logic [`CNT_W-1:0] inst_cnt;

	// dispatch end address
	logic [`ADDR_W-1:0] dsp_end;
	// iterations left in the unroll budget
	logic [`CNT_W-1:0] remain;
	// instructions pushed into the buffer
	logic [`CNT_W-1:0] stall_cnt;

	// end address compare against the bundle
	logic [`ADDR_W-1:0] end_addr;
	logic end_hit;
	logic [$clog2(`LANES)-1:0] end_lane;
	// lanes up to and including the end lane
	logic [$clog2(`LANES):0] lanes_upto;

	// next counter values before saturation
	logic [`CNT_W:0] trn_sum;
	logic [`CNT_W:0] stall_sum;
	// BUF_SLOTS divided by the body length
	logic [`CNT_W-1:0] unroll_q;
	// idle bundle with an unrecorded back edge
	logic start_train;

	// training compares the branch address
	// dispatch compares the end taken from the table
	assign end_addr = (state == TRAIN) ? trn_end : dsp_end;

	// oldest lane sitting on the loop end
	always_comb begin
		end_hit = 1'b0;
		end_lane = '0;
		for (int i = `LANES - 1; i >= 0; i--) begin
			if (fetch.pc[i] == end_addr) begin
				end_hit = 1'b1;
				end_lane = ($clog2(`LANES))'(i);
			end
		end
	end

	// whole bundle counts when the end is absent
	assign lanes_upto = end_hit ? (($clog2(`LANES) + 1)'(end_lane) + 1'b1) :
		($clog2(`LANES) + 1)'(`LANES);

	assign trn_sum = {1'b0, inst_cnt} + (`CNT_W + 1)'(lanes_upto);
	assign stall_sum = {1'b0, stall_cnt} + (`CNT_W + 1)'(lanes_upto);
	// lanes_upto is at least one so the divisor is never zero
	assign unroll_q = (`CNT_W)'(`BUF_SLOTS / trn_sum);

	assign start_train = (state == IDLE) && !lookup.hit && back_edge.hit;

	// recorded loop reached again
	assign loop_strt = lookup.hit && (state != DISPATCH);

	// training pass closed with a body that fits the buffer
	assign wr_en = (state == TRAIN) && !lookup.hit && end_hit &&
		(trn_sum <= `BUF_SLOTS);

	always_comb begin
		wr_entry.valid = 1'b1;
		wr_entry.start_addr = trn_start;
		wr_entry.end_addr = trn_end;
		wr_entry.body_len = trn_sum[`CNT_W-1:0];
		wr_entry.max_unroll = unroll_q;
	end

	// last budgeted iteration ends in this bundle
	assign fnsh_unrll = (state == DISPATCH) && end_hit && (remain == 1);

	// buffer full
	assign stll_ftch = (stall_cnt >= `BUF_SLOTS);

	// thermometer from lane 0 down to the end lane
	// lane 0 occupies the top bit
	assign inst_valid = (state == DISPATCH) ? ~({`LANES{1'b1}} >> lanes_upto) :
		{`LANES{1'b1}};

	assign lbd_state = state;

	// control state and counters
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			inst_cnt <= '0;
			remain <= '0;
			stall_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (loop_strt) begin
						state <= DISPATCH;
						remain <= lookup.max_unroll;
						stall_cnt <= '0;
					end else if (start_train) begin
						state <= TRAIN;
						inst_cnt <= '0;
					end
				end
				TRAIN: begin
					if (loop_strt) begin
						state <= DISPATCH;
						remain <= lookup.max_unroll;
						stall_cnt <= '0;
					end else if (end_hit) begin
						// write or abandon ends training
						state <= IDLE;
					end else if (trn_sum > `BUF_SLOTS) begin
						// park one past the limit so the count cannot wrap
						inst_cnt <= (`CNT_W)'(`BUF_SLOTS + 1);
					end else begin
						inst_cnt <= trn_sum[`CNT_W-1:0];
					end
				end
				DISPATCH: begin
					if (mis_pred || fnsh_unrll) begin
						state <= IDLE;
						remain <= '0;
						stall_cnt <= '0;
					end else begin
						if (end_hit) begin
							remain <= remain - 1'b1;
						end
						// hold at full while fetch is stalled
						if (stall_sum >= `BUF_SLOTS) begin
							stall_cnt <= (`CNT_W)'(`BUF_SLOTS);
						end else begin
							stall_cnt <= stall_sum[`CNT_W-1:0];
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// latched addresses
	always_ff @(posedge clk) begin
		if (start_train) begin
			trn_end <= back_edge.br_addr;
			trn_start <= back_edge.tgt_addr;
		end
		if (loop_strt) begin
			dsp_end <= lookup.end_addr;
		end
	end

	// a trained loop starts at or before its end
	assert property (@(posedge clk) disable iff (rst)
		wr_en |-> (wr_entry.start_addr <= wr_entry.end_addr))
	else $error("loop_unroll_ctrl: loop written with start above end");

	// recorded budgets are never zero
	// so dispatch always leaves through fnsh_unrll or mis_pred
	assert property (@(posedge clk) disable iff (rst)
		(state == DISPATCH) |-> (remain != '0))
	else $error("loop_unroll_ctrl: dispatch with an empty unroll budget");

	// stall counter only fills while dispatching
	assert property (@(posedge clk) disable iff (rst)
		stll_ftch |-> (state == DISPATCH))
	else $error("loop_unroll_ctrl: fetch stalled outside dispatch");

endmodule

//--- list.f
+incdir+design
design/loop_pkg.sv
design/back_edge_detect.sv
design/loop_addr_table.sv
design/loop_unroll_ctrl.sv
design/loop_buffer_top.sv
bench/loop_buffer_tb.sv
